/* axis_fw_pkg.sv */
// Shared stream widths, check limits and the packed beat type
// for the AXI-stream firewall RTL and its testbench
`default_nettype none

package axis_fw_pkg;

	////////////////////
	// Stream widths
	////////////////////

	// TDATA width in bits
	localparam int DATA_W = 8;

	// TUSER width, tie to zero when unused
	localparam int USER_W = 1;

	// One beat packed, user + last + data
	localparam int BEAT_W = DATA_W + USER_W + 1;

	////////////////////
	// Check limits
	////////////////////

	// Longest legal run of stalled input cycles
	localparam int MAX_STALL = 4;

	// Counter must reach MAX_STALL+1 to flag the fault
	localparam int STALL_CNT_W = $clog2(MAX_STALL + 2);

	// Fixed packet length in beats
	localparam int PKT_LEN = 4;

	// Beat-in-packet counter
	localparam int PKT_CNT_W = $clog2(PKT_LEN + 1);

	////////////////////
	// Beat type
	////////////////////

	// Order matches the usual {tuser, tlast, tdata} concatenation
	typedef struct packed {
		logic [USER_W-1:0] user;
		logic              last;
		logic [DATA_W-1:0] data;
	} beat_t;

endpackage

`default_nettype wire

/* axis_skid_buffer.sv */
// One-entry skid buffer on the slave side of the firewall
// Keeps TREADY a plain register, independent of downstream ready
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer (
	input  wire                S_AXI_ACLK,
	input  wire                S_AXI_ARESETN,
	// Slave port, raw input
	input  wire                i_s_axis_tvalid,
	input  wire axis_fw_pkg::beat_t i_s_beat,
	output logic               o_s_axis_tready,
	// Towards the output stage
	output logic               o_skd_valid,
	output axis_fw_pkg::beat_t o_skd_beat,
	input  wire                i_skd_ready
);

	// Spare entry
	logic               skd_full;
	axis_fw_pkg::beat_t skd_beat;

	////////////////////
	// Fill state
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			skd_full <= 1'b0;
		// Accepted, but downstream refused it
		else if (i_s_axis_tvalid && o_s_axis_tready && !i_skd_ready)
			skd_full <= 1'b1;
		// Held beat taken
		else if (i_skd_ready)
			skd_full <= 1'b0;
	end

	// Capture every accepted beat, only the refused one matters
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_s_axis_tvalid && o_s_axis_tready)
			skd_beat <= i_s_beat;
	end

	// Ready straight from the register
	assign o_s_axis_tready = !skd_full;

	////////////////////
	// Presented beat
	////////////////////

	// Held beat goes first, else the live input
	assign o_skd_valid = i_s_axis_tvalid || skd_full;

	always_comb
	begin
		if (skd_full)
			o_skd_beat = skd_beat;
		else
			o_skd_beat = i_s_beat;
	end

	// No new beat may overwrite a held one still waiting downstream
	a_no_accept_when_full: assert property (
		@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(skd_full && !i_skd_ready) |=> (skd_full && $stable(skd_beat))
	);

endmodule

`default_nettype wire

/* axis_fault_detect.sv */
// Protocol checks on the slave side: change, stall and packet length
// Any failure latches o_fault until the next reset
`timescale 1ns/1ps
`default_nettype none

module axis_fault_detect (
	input  wire                S_AXI_ACLK,
	input  wire                S_AXI_ARESETN,
	// Raw slave inputs, as seen on the port
	input  wire                i_s_axis_tvalid,
	input  wire                i_s_axis_tready,
	input  wire axis_fw_pkg::beat_t i_s_beat,
	// Combinational, this cycle only
	output logic               o_violation,
	// Sticky flag
	output logic               o_fault
);

	// Change check
	logic                                stalled_q;
	logic [axis_fw_pkg::BEAT_W-1:0]      past_beat;
	logic                                change_fault;

	// Stall check
	logic [axis_fw_pkg::STALL_CNT_W-1:0] stall_cnt;
	logic                                stall_fault;

	// Packet length check
	logic [axis_fw_pkg::PKT_CNT_W-1:0]   pkt_cnt;
	logic                                pkt_end;
	logic                                pkt_fault;

	////////////////////
	// Change check
	////////////////////

	// Input stalled on this cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			stalled_q <= 1'b0;
		else
			stalled_q <= i_s_axis_tvalid && !i_s_axis_tready;
	end

	// Last cycle's beat, compared only after a stall
	always_ff @(posedge S_AXI_ACLK)
	begin
		past_beat <= i_s_beat;
	end

	// Stalled beat must not move
	assign change_fault = stalled_q && (past_beat != i_s_beat);

	////////////////////
	// Stall check
	////////////////////

	// Consecutive stalled cycles
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			stall_cnt <= '0;
		else if (!i_s_axis_tvalid || i_s_axis_tready)
			stall_cnt <= '0;
		// Saturate one past the limit so it can't wrap
		else if (int'(stall_cnt) <= axis_fw_pkg::MAX_STALL)
			stall_cnt <= stall_cnt + 1'b1;
	end

	// A run of exactly MAX_STALL cycles is still legal
	assign stall_fault = int'(stall_cnt) > axis_fw_pkg::MAX_STALL;

	////////////////////
	// Packet length
	////////////////////

	// Accepted beats in the current packet
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			pkt_cnt <= '0;
		// Framing is lost once faulted
		else if (o_fault)
			pkt_cnt <= '0;
		else if (i_s_axis_tvalid && i_s_axis_tready)
		begin
			if (i_s_beat.last)
				pkt_cnt <= '0;
			else
				pkt_cnt <= pkt_cnt + 1'b1;
		end
	end

	// Position where TLAST is due
	assign pkt_end = int'(pkt_cnt) == (axis_fw_pkg::PKT_LEN - 1);

	// Early or missing TLAST, judged on any valid beat
	assign pkt_fault = i_s_axis_tvalid && (i_s_beat.last != pkt_end);

	////////////////////
	// Fault flag
	////////////////////

	// Only reported while still healthy
	assign o_violation = !o_fault && (change_fault || stall_fault || pkt_fault);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_fault <= 1'b0;
		else if (o_violation)
			o_fault <= 1'b1;
	end

	// Sticky until reset
	a_fault_sticky: assert property (
		@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_fault |=> o_fault
	);

	// TLAST check keeps the counter inside one packet while healthy
	a_pkt_cnt_range: assert property (
		@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!o_fault |-> (int'(pkt_cnt) < axis_fw_pkg::PKT_LEN)
	);

endmodule

`default_nettype wire

/* axis_out_stage.sv */
// Master-side output register of the firewall
// Forwards beats while healthy, drains the input after a fault
`timescale 1ns/1ps
`default_nettype none

module axis_out_stage (
	input  wire                              S_AXI_ACLK,
	input  wire                              S_AXI_ARESETN,
	// From the skid buffer
	input  wire                              i_skd_valid,
	input  wire axis_fw_pkg::beat_t          i_skd_beat,
	output logic                             o_skd_ready,
	// From the detector
	input  wire                              i_violation,
	input  wire                              i_fault,
	// Master port
	output logic                             o_m_axis_tvalid,
	input  wire                              i_m_axis_tready,
	output logic [axis_fw_pkg::DATA_W-1:0]   o_m_axis_tdata,
	output logic                             o_m_axis_tlast,
	output logic [axis_fw_pkg::USER_W-1:0]   o_m_axis_tuser
);

	// Register free this cycle
	logic out_open;
	// New beat enters the register
	logic load;

	assign out_open = !o_m_axis_tvalid || i_m_axis_tready;

	////////////////////
	// Upstream ready
	////////////////////

	always_comb
	begin
		// Faulted, swallow everything
		if (i_fault)
			o_skd_ready = 1'b1;
		// Offending beat stays out
		else if (i_violation)
			o_skd_ready = 1'b0;
		else
			o_skd_ready = out_open;
	end

	// Healthy path only
	assign load = out_open && i_skd_valid && !i_violation && !i_fault;

	////////////////////
	// Output register
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_m_axis_tvalid <= 1'b0;
		// Presented beat lives until taken
		else if (out_open)
			o_m_axis_tvalid <= load;
	end

	// TLAST cleared on reset, rest of the payload not
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_m_axis_tlast <= 1'b0;
		else if (load)
			o_m_axis_tlast <= i_skd_beat.last;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (load)
		begin
			o_m_axis_tdata <= i_skd_beat.data;
			o_m_axis_tuser <= i_skd_beat.user;
		end
	end

	// Master side holds under back-pressure
	a_master_stable: assert property (
		@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(o_m_axis_tvalid && !i_m_axis_tready) |=>
			(o_m_axis_tvalid && $stable(o_m_axis_tdata)
			&& $stable(o_m_axis_tlast) && $stable(o_m_axis_tuser))
	);

endmodule

`default_nettype wire

/* axis_firewall.sv */
// AXI-stream protocol firewall, a bump between a slave and a master port
// o_fault latches on the first protocol error until reset
`timescale 1ns/1ps
`default_nettype none

module axis_firewall (
	input  wire                            S_AXI_ACLK,
	input  wire                            S_AXI_ARESETN,
	// Slave port
	input  wire                            i_s_axis_tvalid,
	output logic                           o_s_axis_tready,
	input  wire [axis_fw_pkg::DATA_W-1:0]  i_s_axis_tdata,
	input  wire                            i_s_axis_tlast,
	input  wire [axis_fw_pkg::USER_W-1:0]  i_s_axis_tuser,
	// Master port
	output logic                           o_m_axis_tvalid,
	input  wire                            i_m_axis_tready,
	output logic [axis_fw_pkg::DATA_W-1:0] o_m_axis_tdata,
	output logic                           o_m_axis_tlast,
	output logic [axis_fw_pkg::USER_W-1:0] o_m_axis_tuser,
	// Sticky error flag
	output logic                           o_fault
);

	axis_fw_pkg::beat_t s_beat;
	axis_fw_pkg::beat_t skd_beat;
	logic               skd_valid;
	logic               skd_ready;
	logic               violation;

	// Slave inputs as one beat
	assign s_beat = {i_s_axis_tuser, i_s_axis_tlast, i_s_axis_tdata};

	axis_skid_buffer axis_skid_buffer_inst (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.S_AXI_ARESETN   (S_AXI_ARESETN),
		.i_s_axis_tvalid (i_s_axis_tvalid),
		.i_s_beat        (s_beat),
		.o_s_axis_tready (o_s_axis_tready),
		.o_skd_valid     (skd_valid),
		.o_skd_beat      (skd_beat),
		.i_skd_ready     (skd_ready)
	);

	// Watches the port itself, not the skid output
	axis_fault_detect axis_fault_detect_inst (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.S_AXI_ARESETN   (S_AXI_ARESETN),
		.i_s_axis_tvalid (i_s_axis_tvalid),
		.i_s_axis_tready (o_s_axis_tready),
		.i_s_beat        (s_beat),
		.o_violation     (violation),
		.o_fault         (o_fault)
	);

	axis_out_stage axis_out_stage_inst (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.S_AXI_ARESETN   (S_AXI_ARESETN),
		.i_skd_valid     (skd_valid),
		.i_skd_beat      (skd_beat),
		.o_skd_ready     (skd_ready),
		.i_violation     (violation),
		.i_fault         (o_fault),
		.o_m_axis_tvalid (o_m_axis_tvalid),
		.i_m_axis_tready (i_m_axis_tready),
		.o_m_axis_tdata  (o_m_axis_tdata),
		.o_m_axis_tlast  (o_m_axis_tlast),
		.o_m_axis_tuser  (o_m_axis_tuser)
	);

endmodule

`default_nettype wire

/* tb_axis_firewall.sv */
// Testbench for the AXI-stream firewall
// Runs reset, clean traffic, change, packet-length and stall faults with drain
`timescale 1ns/1ps
`default_nettype none

module tb_axis_firewall;

	// Run size
	localparam int N_PKT = 8;
	// Worst case per beat, one idle gap plus a short back-pressure run
	localparam int CYC_PER_BEAT = 6;
	localparam int STALL_MARGIN = 4 * (axis_fw_pkg::MAX_STALL + 10);
	localparam int WATCHDOG_CYC = (N_PKT + 4) * axis_fw_pkg::PKT_LEN * CYC_PER_BEAT
		+ STALL_MARGIN + 100;

	logic                          S_AXI_ACLK;
	logic                          S_AXI_ARESETN;
	logic                          s_valid;
	axis_fw_pkg::beat_t            s_beat;
	logic                          m_ready;
	wire                           s_ready;
	wire                           m_valid;
	wire [axis_fw_pkg::DATA_W-1:0] m_data;
	wire                           m_last;
	wire [axis_fw_pkg::USER_W-1:0] m_user;
	wire                           fault;
	axis_fw_pkg::beat_t            m_beat;

	// Expected master sequence
	axis_fw_pkg::beat_t exp_q[$];
	axis_fw_pkg::beat_t exp_head;
	logic               exp_empty;
	// Beat on the input is meant to come out
	logic               beat_good;

	// Check enables, set on the falling edge
	logic  chk_reset;
	logic  chk_no_fault;
	logic  chk_fault;
	logic  chk_empty;

	int    seed;
	int    err_cnt;
	int    test_err_base;
	int    tests_run;
	int    tests_failed;
	int    low_run;
	logic  rand_ready;
	string test_name;

	axis_firewall axis_firewall_inst (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.S_AXI_ARESETN   (S_AXI_ARESETN),
		.i_s_axis_tvalid (s_valid),
		.o_s_axis_tready (s_ready),
		.i_s_axis_tdata  (s_beat.data),
		.i_s_axis_tlast  (s_beat.last),
		.i_s_axis_tuser  (s_beat.user),
		.o_m_axis_tvalid (m_valid),
		.i_m_axis_tready (m_ready),
		.o_m_axis_tdata  (m_data),
		.o_m_axis_tlast  (m_last),
		.o_m_axis_tuser  (m_user),
		.o_fault         (fault)
	);

	assign m_beat = {m_user, m_last, m_data};

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #5 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	////////////////////
	// Scoreboard
	////////////////////

	// Pop on delivery first, then push the newly accepted beat
	always @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			exp_q.delete();
		else
		begin
			if (m_valid && m_ready && exp_q.size() > 0)
				void'(exp_q.pop_front());
			if (s_valid && s_ready && beat_good && !fault)
				exp_q.push_back(s_beat);
		end
		exp_empty <= (exp_q.size() == 0);
		if (exp_q.size() > 0)
			exp_head <= exp_q[0];
	end

	task automatic log_error(input string msg);
		err_cnt++;
		$display("%s", msg);
	endtask

	////////////////////
	// Checks
	////////////////////

	a_reset_state: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		chk_reset |-> (!m_valid && !fault && s_ready))
		else log_error($sformatf("FAILED %s: {tvalid,fault,tready} expected 001 actual %b",
			test_name, {$sampled(m_valid), $sampled(fault), $sampled(s_ready)}));

	// Delivered beats follow acceptance order
	a_scoreboard: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(m_valid && m_ready) |-> (!exp_empty && m_beat == exp_head))
		else log_error($sformatf("FAILED %s: master beat expected %h actual %h (queue empty %b)",
			test_name, $sampled(exp_head), $sampled(m_beat), $sampled(exp_empty)));

	a_no_fault: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		chk_no_fault |-> !fault)
		else log_error($sformatf("FAILED %s: o_fault expected 0 actual 1", test_name));

	a_fault_set: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		chk_fault |-> fault)
		else log_error($sformatf("FAILED %s: o_fault expected 1 actual 0", test_name));

	a_all_delivered: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		chk_empty |-> exp_empty)
		else log_error($sformatf("Error in %s: accepted beats never came out", test_name));

	a_master_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(m_valid && !m_ready) |=> (m_valid && $stable(m_beat)))
		else log_error($sformatf("Error in %s: master outputs moved under back-pressure",
			test_name));

	a_fault_sticky: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		fault |=> fault)
		else log_error($sformatf("Error in %s: o_fault dropped without a reset", test_name));

	// Input drains once the fault is in
	a_drain_ready: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		fault |=> s_ready)
		else log_error($sformatf("Error in %s: slave tready low after the fault", test_name));

	// Only the already presented beat may leave
	a_drain_quiet: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(fault && (!m_valid || m_ready)) |=> !m_valid)
		else log_error($sformatf("Error in %s: new beat presented after the fault", test_name));

	////////////////////
	// Stimulus
	////////////////////

	function automatic axis_fw_pkg::beat_t random_beat(input logic last);
		axis_fw_pkg::beat_t b;
		int                 r;
		r = $random(seed);
		b.data = r[axis_fw_pkg::DATA_W-1:0];
		b.user = r[16 +: axis_fw_pkg::USER_W];
		b.last = last;
		return b;
	endfunction

	// One clock; random master ready when enabled, low runs capped at 3
	task automatic next_cycle();
		int r;
		@(negedge S_AXI_ACLK);
		if (rand_ready)
		begin
			r = $random(seed);
			m_ready = (low_run >= 3) || r[0];
			low_run = m_ready ? 0 : low_run + 1;
		end
	endtask

	// Ready is registered, so the level seen here decides the coming edge
	task automatic send_beat(input axis_fw_pkg::beat_t b, input logic good);
		s_valid = 1'b1;
		s_beat = b;
		beat_good = good;
		while (!s_ready)
			next_cycle();
		next_cycle();
		s_valid = 1'b0;
	endtask

	task automatic idle_inputs();
		s_valid = 1'b0;
		s_beat = '0;
		m_ready = 1'b0;
		rand_ready = 1'b0;
		beat_good = 1'b0;
		{chk_reset, chk_no_fault, chk_fault, chk_empty} = '0;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err_base = err_cnt;
		@(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b0;
		idle_inputs();
		repeat (4) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
	endtask

	task automatic end_test();
		tests_run++;
		if (err_cnt != test_err_base)
			tests_failed++;
		$display("test %s finished, %0d errors", test_name, err_cnt - test_err_base);
	endtask

	// Keep feeding input with the master ready, fault must hold
	task automatic drain_after_fault();
		m_ready = 1'b1;
		chk_fault = 1'b1;
		s_valid = 1'b1;
		beat_good = 1'b0;
		repeat (8)
		begin
			s_beat = random_beat(1'b0);
			next_cycle();
		end
		s_valid = 1'b0;
		next_cycle();
		chk_fault = 1'b0;
	endtask

	initial
	begin
		seed = 32'h4b8b_ac66;
		{err_cnt, tests_run, tests_failed, low_run} = '0;
		S_AXI_ARESETN = 1'b0;
		idle_inputs();

		start_test("reset_state");
		chk_reset = 1'b1;
		next_cycle();
		end_test();

		// Well-formed packets, random gaps and back-pressure
		start_test("clean_traffic");
		chk_no_fault = 1'b1;
		rand_ready = 1'b1;
		for (int p = 0; p < N_PKT; p++)
			for (int i = 0; i < axis_fw_pkg::PKT_LEN; i++)
			begin
				if ($random(seed) % 4 == 0)
					next_cycle();
				send_beat(random_beat(i == axis_fw_pkg::PKT_LEN - 1), 1'b1);
			end
		for (int n = 0; n < 32 && !exp_empty; n++)
			next_cycle();
		chk_empty = 1'b1;
		next_cycle();
		end_test();

		// Fill the skid, then move the stalled beat
		start_test("change_fault");
		send_beat(random_beat(1'b0), 1'b1);
		send_beat(random_beat(1'b0), 1'b1);
		s_valid = 1'b1;
		s_beat = random_beat(1'b0);
		beat_good = 1'b0;
		while (s_ready)
			next_cycle();
		next_cycle();
		s_beat.data = ~s_beat.data;
		next_cycle();
		drain_after_fault();
		end_test();

		// TLAST on beat two
		start_test("packet_length");
		m_ready = 1'b1;
		send_beat(random_beat(1'b0), 1'b1);
		s_valid = 1'b1;
		s_beat = random_beat(1'b1);
		beat_good = 1'b0;
		next_cycle();
		drain_after_fault();
		end_test();

		// Legal stall of MAX_STALL cycles first
		start_test("stall_fault");
		chk_no_fault = 1'b1;
		send_beat(random_beat(1'b0), 1'b1);
		send_beat(random_beat(1'b0), 1'b1);
		s_valid = 1'b1;
		s_beat = random_beat(1'b0);
		beat_good = 1'b1;
		repeat (axis_fw_pkg::MAX_STALL - 1)
			next_cycle();
		m_ready = 1'b1;
		send_beat(s_beat, 1'b1);
		send_beat(random_beat(1'b1), 1'b1);
		repeat (4)
			next_cycle();
		// Then one that runs too long
		m_ready = 1'b0;
		send_beat(random_beat(1'b0), 1'b1);
		send_beat(random_beat(1'b0), 1'b1);
		s_valid = 1'b1;
		s_beat = random_beat(1'b0);
		// No fault yet through MAX_STALL+1 stalled cycles
		repeat (axis_fw_pkg::MAX_STALL + 1)
			next_cycle();
		chk_no_fault = 1'b0;
		next_cycle();
		drain_after_fault();
		end_test();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (WATCHDOG_CYC) @(posedge S_AXI_ACLK);
		$display("Timeout, run still going after %0d cycles", WATCHDOG_CYC);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
axis_fw_pkg.sv
axis_skid_buffer.sv
axis_fault_detect.sv
axis_out_stage.sv
axis_firewall.sv
tb_axis_firewall.sv

/* Makefile */
# Verilator flow for the AXI-stream firewall testbench
# make builds and runs, make lint checks the RTL, make clean tidies up

VERILATOR  ?= verilator
TOP        ?= tb_axis_firewall
RTL_TOP    ?= axis_firewall
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= sim passed
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES  := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter-out $(TOP).sv,$(SOURCES))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the exit code of the binary
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Pass line missing in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
